//--- console_io.f
hw/console_pkg.sv
hw/io_bus_decode.sv
hw/snes_cont.sv
hw/rotary_encoder.sv
hw/rom_controller.sv
hw/vga_timing.sv
hw/console_io.sv
testbench/console_io_chk.sv
testbench/console_io_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= console_io_tb
FILELIST ?= console_io.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	grep -qx "test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- testbench/console_io_tb.sv
`timescale 1ns/1ps
module console_io_tb;
	localparam int H_TOTAL = 40;
	localparam int V_TOTAL = 12;
	localparam int DECODE_LOOPS = 16;
	localparam int ROT_STEPS = 32;
	localparam int FLASH_READS = 40;
	localparam int PAD_FRAMES = 8;
	// bus operations and encoder steps of all sections
	localparam int OPS = DECODE_LOOPS * 3 + 3 + ROT_STEPS + 4 + FLASH_READS * 12 + PAD_FRAMES + 2;
	localparam int FRAMES = PAD_FRAMES + 4;
	localparam int TIMEOUT_CYCLES = OPS * 200 + FRAMES * H_TOTAL * V_TOTAL * 2;

	logic clk = 1'b0;
	logic rst;
	console_pkg::bus_req_t bus;
	logic [7:0] switches;
	logic data = 1'b1;
	logic rot_a;
	logic rot_b;
	logic [15:0] sf_d = 16'h0000;
	logic [15:0] memdata;
	logic latch;
	logic pulse;
	logic [23:0] sf_a;
	logic sf_ce0;
	logic sf_oe;
	logic sf_we;
	logic sf_byte;
	console_pkg::vga_sync_t sync;

	integer seed;

	// pad model state
	logic [15:0] pad_sreg;
	console_pkg::snes_pad_t pad_loaded;
	logic latch_d;
	logic pulse_d;

	// frame model state
	logic vsync_d;
	logic [15:0] frame_count;

	always #10 clk = ~clk;

	console_io u_console_io (
		.clk(clk),
		.rst(rst),
		.bus(bus),
		.switches(switches),
		.data(data),
		.rot_a(rot_a),
		.rot_b(rot_b),
		.sf_d(sf_d),
		.memdata(memdata),
		.latch(latch),
		.pulse(pulse),
		.sf_a(sf_a),
		.sf_ce0(sf_ce0),
		.sf_oe(sf_oe),
		.sf_we(sf_we),
		.sf_byte(sf_byte),
		.sync(sync)
	);

	// flash contents as a function of the word address
	function automatic logic [15:0] flash_word(input logic [23:0] a);
		return a[15:0] ^ 16'hA5C3 ^ {8'h00, a[23:16]};
	endfunction

	always @(posedge clk) begin
		sf_d <= flash_word(sf_a);
	end

	// model register holds pressed as 1 with the low nibble released
	always @(posedge clk) begin : pad_model
		logic [31:0] r;
		latch_d <= latch;
		pulse_d <= pulse;
		if (latch && !latch_d) begin
			r = $random(seed);
			pad_loaded <= console_pkg::snes_pad_t'(r[11:0]);
			pad_sreg <= {r[11:0], 4'h0};
			data <= ~r[11];
		end else if (pulse && !pulse_d) begin
			pad_sreg <= {pad_sreg[14:0], 1'b0};
			data <= ~pad_sreg[14];
		end
	end

	// count vsync falls independently of the DUT
	always @(negedge clk) begin
		if (rst) begin
			vsync_d <= 1'b1;
			frame_count <= 16'h0000;
		end else begin
			vsync_d <= sync.vsync;
			if (vsync_d && !sync.vsync) begin
				frame_count <= frame_count + 16'd1;
			end
		end
	end

	task automatic check_word(input string name, input logic [15:0] expected,
			input logic [15:0] actual);
		if (actual !== expected) begin
			$display("ERROR time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
			$display("test failed");
			$fatal(1);
		end
	endtask

	task automatic check_pad(input string name, input console_pkg::snes_pad_t expected,
			input console_pkg::snes_pad_t actual);
		if (actual !== expected) begin
			$display("ERROR time=%0t %s expected=%b actual=%b", $time, name, expected, actual);
			$display("test failed");
			$fatal(1);
		end
	endtask

	task automatic check_sync(input string name, input console_pkg::vga_sync_t expected,
			input console_pkg::vga_sync_t actual);
		if (actual !== expected) begin
			$display("ERROR time=%0t %s expected=%b actual=%b", $time, name, expected, actual);
			$display("test failed");
			$fatal(1);
		end
	endtask

	task automatic write_reg(input logic [15:0] a, input logic [15:0] d);
		@(posedge clk);
		bus <= '{addr: a, wdata: d, write: 1'b1};
		@(posedge clk);
		bus <= '0;
	endtask

	// memdata follows the address by one cycle
	task automatic read_reg(input logic [15:0] a, output logic [15:0] value);
		@(posedge clk);
		bus <= '{addr: a, wdata: 16'h0000, write: 1'b0};
		@(posedge clk);
		bus <= '0;
		@(negedge clk);
		value = memdata;
	endtask

	function automatic logic [15:0] random_unmapped();
		logic [31:0] r;
		r = $random(seed);
		// keep clear of FF00..FF07
		if (r[15:3] == 13'h1FE0) begin
			r[8] = 1'b0;
		end
		return r[15:0];
	endfunction

	// one full quadrature cycle where cw means a leads b
	task automatic turn_encoder(input logic cw);
		logic [7:0] gray;
		gray = cw ? 8'b10_11_01_00 : 8'b01_11_10_00;
		for (int i = 3; i >= 0; i--) begin
			@(posedge clk);
			{rot_a, rot_b} <= gray[2*i +: 2];
			repeat (3) @(posedge clk);
		end
	endtask

	initial begin : watchdog
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("test failed");
		$fatal(1);
	end

	initial begin : main
		logic [15:0] v;
		logic [15:0] rot_expect;
		logic [23:0] fa;
		logic [31:0] r;
		console_pkg::vga_sync_t sync_rst;
		seed = 32'h17cb593f;
		rst = 1'b1;
		bus = '0;
		switches = 8'h00;
		rot_a = 1'b0;
		rot_b = 1'b0;
		sync_rst = '{hsync: 1'b1, vsync: 1'b1, bright: 1'b0};

		// reset state is checked while rst is still high
		repeat (15) @(posedge clk);
		@(negedge clk);
		check_sync("sync", sync_rst, sync);
		check_word("{latch,pulse,sf_ce0,sf_oe,sf_we,sf_byte}", 16'h000F,
			{10'h000, latch, pulse, sf_ce0, sf_oe, sf_we, sf_byte});
		@(posedge clk);
		rst <= 1'b0;

		// decode
		for (int i = 0; i < DECODE_LOOPS; i++) begin
			@(negedge clk);
			r = $random(seed);
			@(posedge clk);
			switches <= r[7:0];
			read_reg(console_pkg::ADDR_SWITCHES, v);
			check_word("memdata(SWITCHES)", {8'h00, r[7:0]}, v);
			read_reg(random_unmapped(), v);
			check_word("memdata(unmapped)", 16'h0000, v);
			write_reg(random_unmapped(), r[31:16]);
		end
		read_reg(console_pkg::ADDR_ROT, v);
		check_word("memdata(ROT)", 16'h0000, v);
		read_reg(console_pkg::ADDR_ROM_LO, v);
		check_word("memdata(ROM_LO)", 16'h0000, v);
		read_reg(console_pkg::ADDR_ROM_HI, v);
		check_word("memdata(ROM_HI)", 16'h0000, v);

		// rotary
		r = $random(seed);
		rot_expect = r[15:0];
		write_reg(console_pkg::ADDR_ROT, rot_expect);
		read_reg(console_pkg::ADDR_ROT, v);
		check_word("memdata(ROT)", rot_expect, v);
		for (int i = 0; i < ROT_STEPS; i++) begin
			@(negedge clk);
			r = $random(seed);
			turn_encoder(r[0]);
			rot_expect = r[0] ? rot_expect + 16'd1 : rot_expect - 16'd1;
		end
		repeat (4) @(posedge clk);
		read_reg(console_pkg::ADDR_ROT, v);
		check_word("memdata(ROT)", rot_expect, v);

		// flash
		for (int i = 0; i < FLASH_READS; i++) begin
			r = $random(seed);
			fa = r[23:0];
			write_reg(console_pkg::ADDR_ROM_LO, fa[15:0]);
			write_reg(console_pkg::ADDR_ROM_HI, {8'h00, fa[23:16]});
			// retarget attempt while the read is in flight
			if (i % 4 == 3) begin
				write_reg(console_pkg::ADDR_ROM_HI, {8'h00, ~fa[23:16]});
			end
			do begin
				read_reg(console_pkg::ADDR_ROM_STAT, v);
			end while (!v[0]);
			read_reg(console_pkg::ADDR_ROM_DATA, v);
			check_word("memdata(ROM_DATA)", flash_word(fa), v);
			read_reg(console_pkg::ADDR_ROM_HI, v);
			check_word("memdata(ROM_HI)", {8'h00, fa[23:16]}, v);
		end

		// one pad poll per frame
		for (int f = 0; f < PAD_FRAMES; f++) begin
			do @(negedge clk); while (!latch);
			for (int p = 0; p < console_pkg::SNES_BITS; p++) begin
				do @(negedge clk); while (!pulse);
				do @(negedge clk); while (pulse);
			end
			repeat (2) @(negedge clk);
			read_reg(console_pkg::ADDR_PAD, v);
			check_pad("memdata(PAD)", pad_loaded, console_pkg::snes_pad_t'(v[11:0]));
		end

		// frame counter read well inside the vsync pulse
		do @(negedge clk); while (sync.vsync);
		repeat (4) @(negedge clk);
		read_reg(console_pkg::ADDR_FRAME, v);
		check_word("memdata(FRAME)", frame_count, v);

		$display("test passed");
		$finish;
	end

endmodule

//--- testbench/console_io_chk.sv
`timescale 1ns/1ps
module console_io_chk (
	input logic        clk,
	input logic        rst,
	input logic        latch,
	input logic        pulse,
	input logic        sf_ce0,
	input logic        sf_oe,
	input logic [23:0] sf_a,
	input logic        rom_ready,
	input logic        frame_start
);
	// pad poll phases never overlap
	latch_pulse: assert property (@(posedge clk) disable iff (rst) !(latch && pulse))
		else $error("latch and pulse high together");

	oe_needs_ce: assert property (@(posedge clk) disable iff (rst) !sf_oe |-> !sf_ce0)
		else $error("sf_oe low while sf_ce0 high");

	// address held for the whole access
	addr_stable: assert property (@(posedge clk) disable iff (rst) !rom_ready |=> $stable(sf_a))
		else $error("sf_a changed during a flash read");

	frame_single: assert property (@(posedge clk) disable iff (rst) frame_start |=> !frame_start)
		else $error("frame_start high for two cycles");

endmodule

bind console_io console_io_chk u_chk (
	.clk(clk),
	.rst(rst),
	.latch(latch),
	.pulse(pulse),
	.sf_ce0(sf_ce0),
	.sf_oe(sf_oe),
	.sf_a(sf_a),
	.rom_ready(rom_ready),
	.frame_start(frame_start)
);

//--- hw/console_io.sv
`timescale 1ns/1ps
module console_io #(
	parameter int SNES_DIV = 4,
	parameter int ROM_WAIT = 5,
	parameter int H_TOTAL = 40,
	parameter int H_ACTIVE = 32,
	parameter int V_TOTAL = 12,
	parameter int V_ACTIVE = 8
) (
	input  logic                   clk,
	input  logic                   rst,
	input  console_pkg::bus_req_t  bus,
	input  logic [7:0]             switches,
	input  logic                   data,
	input  logic                   rot_a,
	input  logic                   rot_b,
	input  logic [15:0]            sf_d,
	output logic [15:0]            memdata,
	output logic                   latch,
	output logic                   pulse,
	output logic [23:0]            sf_a,
	output logic                   sf_ce0,
	output logic                   sf_oe,
	output logic                   sf_we,
	output logic                   sf_byte,
	output console_pkg::vga_sync_t sync
);
	console_pkg::snes_pad_t pad;
	logic [15:0] rot_count;
	logic rot_write;
	logic [15:0] rot_value;
	logic [23:0] rom_addr;
	logic [15:0] rom_data;
	logic rom_load;
	logic rom_ready;
	logic frame_start;

	// flash is read only, word mode
	assign sf_we = 1'b1;
	assign sf_byte = 1'b1;

	io_bus_decode u_decode (
		.clk(clk),
		.rst(rst),
		.bus(bus),
		.switches(switches),
		.pad(pad),
		.rot_count(rot_count),
		.rom_data(rom_data),
		.rom_ready(rom_ready),
		.frame_start(frame_start),
		.memdata(memdata),
		.rot_write(rot_write),
		.rot_value(rot_value),
		.rom_addr(rom_addr),
		.rom_load(rom_load)
	);

	// pad poll kicked off once per frame
	snes_cont #(.SNES_DIV(SNES_DIV)) u_snes (
		.clk(clk),
		.rst(rst),
		.en(frame_start),
		.data(data),
		.latch(latch),
		.pulse(pulse),
		.pad(pad)
	);

	rotary_encoder u_rot (
		.clk(clk),
		.rst(rst),
		.rot_a(rot_a),
		.rot_b(rot_b),
		.write(rot_write),
		.value(rot_value),
		.count(rot_count)
	);

	rom_controller #(.ROM_WAIT(ROM_WAIT)) u_rom (
		.clk(clk),
		.rst(rst),
		.addr(rom_addr),
		.load(rom_load),
		.sf_d(sf_d),
		.data(rom_data),
		.ready(rom_ready),
		.sf_a(sf_a),
		.sf_ce0(sf_ce0),
		.sf_oe(sf_oe)
	);

	vga_timing #(
		.H_TOTAL(H_TOTAL),
		.H_ACTIVE(H_ACTIVE),
		.V_TOTAL(V_TOTAL),
		.V_ACTIVE(V_ACTIVE)
	) u_vga (
		.clk(clk),
		.rst(rst),
		.sync(sync),
		.frame_start(frame_start)
	);

endmodule

//--- hw/vga_timing.sv
`timescale 1ns/1ps
module vga_timing #(
	parameter int H_TOTAL = 40,
	parameter int H_ACTIVE = 32,
	parameter int V_TOTAL = 12,
	parameter int V_ACTIVE = 8
) (
	input  logic                   clk,
	input  logic                   rst,
	output console_pkg::vga_sync_t sync,
	output logic                   frame_start
);
	localparam int HW = $clog2(H_TOTAL);
	localparam int VW = $clog2(V_TOTAL);

	logic [HW-1:0] h_cnt;
	logic [VW-1:0] v_cnt;
	logic hs_next;
	logic vs_next;
	logic br_next;
	logic line_end;

	assign line_end = h_cnt == HW'(H_TOTAL - 1);

	always_comb begin
		// 4 clock hsync after a short front porch
		hs_next = !((h_cnt >= HW'(H_ACTIVE + 2)) && (h_cnt < HW'(H_ACTIVE + 6)));
		vs_next = v_cnt != VW'(V_ACTIVE + 1);
		br_next = (h_cnt < HW'(H_ACTIVE)) && (v_cnt < VW'(V_ACTIVE));
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (line_end) begin
			h_cnt <= '0;
			if (v_cnt == VW'(V_TOTAL - 1)) begin
				v_cnt <= '0;
			end else begin
				v_cnt <= v_cnt + 1'b1;
			end
		end else begin
			h_cnt <= h_cnt + 1'b1;
		end
	end

	// registered outputs, frame_start lines up with the vsync fall
	always_ff @(posedge clk) begin
		if (rst) begin
			sync <= '{hsync: 1'b1, vsync: 1'b1, bright: 1'b0};
			frame_start <= 1'b0;
		end else begin
			sync.hsync <= hs_next;
			sync.vsync <= vs_next;
			sync.bright <= br_next;
			frame_start <= sync.vsync & ~vs_next;
		end
	end

endmodule

//--- hw/rom_controller.sv
`timescale 1ns/1ps
module rom_controller #(
	parameter int ROM_WAIT = 5
) (
	input  logic        clk,
	input  logic        rst,
	input  logic [23:0] addr,
	input  logic        load,
	input  logic [15:0] sf_d,
	output logic [15:0] data,
	output logic        ready,
	output logic [23:0] sf_a,
	output logic        sf_ce0,
	output logic        sf_oe
);
	localparam int CW = $clog2(ROM_WAIT + 1);

	console_pkg::rom_state_e state;
	logic [CW-1:0] wait_cnt;
	logic busy;

	assign busy = state == console_pkg::RD_WAIT;

	// chip enable and output enable follow the access window
	assign ready = ~busy;
	assign sf_ce0 = ~busy;
	assign sf_oe = ~busy;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= console_pkg::RD_IDLE;
			wait_cnt <= '0;
			sf_a <= 24'h000000;
			data <= 16'h0000;
		end else begin
			case (state)
				console_pkg::RD_IDLE: begin
					wait_cnt <= '0;
					if (load) begin
						// address held until capture
						sf_a <= addr;
						state <= console_pkg::RD_WAIT;
					end
				end
				console_pkg::RD_WAIT: begin
					if (wait_cnt == CW'(ROM_WAIT - 1)) begin
						data <= sf_d;
						state <= console_pkg::RD_IDLE;
					end else begin
						wait_cnt <= wait_cnt + 1'b1;
					end
				end
				default: state <= console_pkg::RD_IDLE;
			endcase
		end
	end

endmodule

//--- hw/rotary_encoder.sv
`timescale 1ns/1ps
module rotary_encoder (
	input  logic        clk,
	input  logic        rst,
	input  logic        rot_a,
	input  logic        rot_b,
	input  logic        write,
	input  logic [15:0] value,
	output logic [15:0] count
);
	// {a, b} through two flops
	logic [1:0] meta;
	logic [1:0] sync;
	logic a_prev;
	logic a_rise;

	assign a_rise = sync[1] & ~a_prev;

	always_ff @(posedge clk) begin
		if (rst) begin
			meta <= 2'b00;
			sync <= 2'b00;
			a_prev <= 1'b0;
		end else begin
			meta <= {rot_a, rot_b};
			sync <= meta;
			a_prev <= sync[1];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			count <= 16'h0000;
		end else if (write) begin
			count <= value;
		end else if (a_rise) begin
			// b still low means a led
			if (sync[0]) begin
				count <= count - 16'd1;
			end else begin
				count <= count + 16'd1;
			end
		end
	end

endmodule

//--- hw/snes_cont.sv
`timescale 1ns/1ps
module snes_cont #(
	parameter int SNES_DIV = 4
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   en,
	input  logic                   data,
	output logic                   latch,
	output logic                   pulse,
	output console_pkg::snes_pad_t pad
);
	localparam int TW = $clog2(2 * SNES_DIV);
	localparam int BW = $clog2(console_pkg::SNES_BITS);

	console_pkg::snes_state_e state;
	logic [TW-1:0] timer;
	logic [BW-1:0] bit_cnt;
	logic [console_pkg::SNES_BITS-1:0] shreg;
	logic half_done;
	logic latch_done;

	assign half_done = timer == TW'(SNES_DIV - 1);
	assign latch_done = timer == TW'(2 * SNES_DIV - 1);

	assign latch = state == console_pkg::SNES_LATCH;
	assign pulse = state == console_pkg::SNES_PULSE_HI;

	// shift register of raw samples
	always_ff @(posedge clk) begin
		if (rst) begin
			shreg <= '0;
		end else if ((state == console_pkg::SNES_LATCH && latch_done) ||
		    (state == console_pkg::SNES_PULSE_LO && half_done)) begin
			shreg <= {shreg[console_pkg::SNES_BITS-2:0], ~data};
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= console_pkg::SNES_IDLE;
			timer <= '0;
			bit_cnt <= '0;
			pad <= '0;
		end else begin
			case (state)
				console_pkg::SNES_IDLE: begin
					timer <= '0;
					if (en) begin
						state <= console_pkg::SNES_LATCH;
					end
				end
				console_pkg::SNES_LATCH: begin
					if (latch_done) begin
						timer <= '0;
						bit_cnt <= '0;
						state <= console_pkg::SNES_PULSE_LO;
					end else begin
						timer <= timer + 1'b1;
					end
				end
				console_pkg::SNES_PULSE_LO: begin
					if (half_done) begin
						timer <= '0;
						state <= console_pkg::SNES_PULSE_HI;
					end else begin
						timer <= timer + 1'b1;
					end
				end
				console_pkg::SNES_PULSE_HI: begin
					if (half_done) begin
						timer <= '0;
						if (bit_cnt == BW'(console_pkg::SNES_BITS - 1)) begin
							// buttons sit in the top 12 bits once the poll completes
							pad <= console_pkg::snes_pad_t'(shreg[console_pkg::SNES_BITS-1 -: 12]);
							state <= console_pkg::SNES_IDLE;
						end else begin
							bit_cnt <= bit_cnt + 1'b1;
							state <= console_pkg::SNES_PULSE_LO;
						end
					end else begin
						timer <= timer + 1'b1;
					end
				end
				default: state <= console_pkg::SNES_IDLE;
			endcase
		end
	end

endmodule

//--- hw/io_bus_decode.sv
`timescale 1ns/1ps
module io_bus_decode (
	input  logic                   clk,
	input  logic                   rst,
	input  console_pkg::bus_req_t  bus,
	input  logic [7:0]             switches,
	input  console_pkg::snes_pad_t pad,
	input  logic [15:0]            rot_count,
	input  logic [15:0]            rom_data,
	input  logic                   rom_ready,
	input  logic                   frame_start,
	output logic [15:0]            memdata,
	output logic                   rot_write,
	output logic [15:0]            rot_value,
	output logic [23:0]            rom_addr,
	output logic                   rom_load
);
	console_pkg::io_reg_e sel;
	logic [15:0] rom_lo;
	logic [7:0] rom_hi;
	logic [15:0] frame_cnt;
	logic hi_accept;
	logic [15:0] rd_mux;

	// address to register select
	always_comb begin
		case (bus.addr)
			console_pkg::ADDR_SWITCHES: sel = console_pkg::REG_SWITCHES;
			console_pkg::ADDR_PAD:      sel = console_pkg::REG_PAD;
			console_pkg::ADDR_ROT:      sel = console_pkg::REG_ROT;
			console_pkg::ADDR_ROM_LO:   sel = console_pkg::REG_ROM_LO;
			console_pkg::ADDR_ROM_HI:   sel = console_pkg::REG_ROM_HI;
			console_pkg::ADDR_ROM_DATA: sel = console_pkg::REG_ROM_DATA;
			console_pkg::ADDR_ROM_STAT: sel = console_pkg::REG_ROM_STAT;
			console_pkg::ADDR_FRAME:    sel = console_pkg::REG_FRAME;
			default:                    sel = console_pkg::REG_NONE;
		endcase
	end

	assign rot_write = bus.write && (sel == console_pkg::REG_ROT);
	assign rot_value = bus.wdata;

	// a rom_hi write only counts when the flash side is free
	assign hi_accept = bus.write && (sel == console_pkg::REG_ROM_HI) && rom_ready && !rom_load;

	assign rom_addr = {rom_hi, rom_lo};

	always_comb begin
		case (sel)
			console_pkg::REG_SWITCHES: rd_mux = {8'h00, switches};
			console_pkg::REG_PAD:      rd_mux = {4'h0, pad};
			console_pkg::REG_ROT:      rd_mux = rot_count;
			console_pkg::REG_ROM_LO:   rd_mux = rom_lo;
			console_pkg::REG_ROM_HI:   rd_mux = {8'h00, rom_hi};
			console_pkg::REG_ROM_DATA: rd_mux = rom_data;
			// load in flight already counts as busy
			console_pkg::REG_ROM_STAT: rd_mux = {15'd0, rom_ready & ~rom_load};
			console_pkg::REG_FRAME:    rd_mux = frame_cnt;
			default:                   rd_mux = 16'h0000;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rom_lo <= 16'h0000;
			rom_hi <= 8'h00;
			frame_cnt <= 16'h0000;
			rom_load <= 1'b0;
			memdata <= 16'h0000;
		end else begin
			rom_load <= hi_accept;
			if (bus.write && (sel == console_pkg::REG_ROM_LO)) begin
				rom_lo <= bus.wdata;
			end
			if (hi_accept) begin
				rom_hi <= bus.wdata[7:0];
			end
			// wraps at 2^16
			if (frame_start) begin
				frame_cnt <= frame_cnt + 16'd1;
			end
			memdata <= rd_mux;
		end
	end

endmodule

//--- hw/console_pkg.sv
package console_pkg;

	// one processor bus transfer, driven every cycle
	typedef struct packed {
		logic [15:0] addr;
		logic [15:0] wdata;
		logic        write;
	} bus_req_t;

	// button states in shift order, msb first, 1 = pressed
	typedef struct packed {
		logic b;
		logic y;
		logic select;
		logic start;
		logic up;
		logic down;
		logic left;
		logic right;
		logic a;
		logic x;
		logic l;
		logic r;
	} snes_pad_t;

	// syncs are active low
	typedef struct packed {
		logic hsync;
		logic vsync;
		logic bright;
	} vga_sync_t;

	typedef enum logic [3:0] {
		REG_SWITCHES,
		REG_PAD,
		REG_ROT,
		REG_ROM_LO,
		REG_ROM_HI,
		REG_ROM_DATA,
		REG_ROM_STAT,
		REG_FRAME,
		REG_NONE
	} io_reg_e;

	// io register map
	localparam logic [15:0] ADDR_SWITCHES = 16'hFF00;
	localparam logic [15:0] ADDR_PAD      = 16'hFF01;
	localparam logic [15:0] ADDR_ROT      = 16'hFF02;
	localparam logic [15:0] ADDR_ROM_LO   = 16'hFF03;
	localparam logic [15:0] ADDR_ROM_HI   = 16'hFF04;
	localparam logic [15:0] ADDR_ROM_DATA = 16'hFF05;
	localparam logic [15:0] ADDR_ROM_STAT = 16'hFF06;
	localparam logic [15:0] ADDR_FRAME    = 16'hFF07;

	typedef enum logic [1:0] {
		SNES_IDLE,
		SNES_LATCH,
		SNES_PULSE_LO,
		SNES_PULSE_HI
	} snes_state_e;

	typedef enum logic {
		RD_IDLE,
		RD_WAIT
	} rom_state_e;

	// pulses per poll, only the first 12 bits are buttons
	localparam int SNES_BITS = 16;

endpackage
